// File: eth_tx_top.f
src/eth_tx_pkg.sv
src/arp_tx_gen.sv
src/buf_mng.sv
src/mac_tx_framer.sv
src/eth_tx_top.sv
verification/eth_tx_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the eth_tx testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=eth_tx_tb
OBJ_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module "$TOP" \
  --Mdir "$OBJ_DIR" \
  -o "$TOP" \
  -f eth_tx_top.f
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

"./$OBJ_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
  echo "Result: FAIL"
  exit 1
fi
echo "Result: PASS"
exit 0

// File: verification/eth_tx_tb.sv
`timescale 1ns/1ps

module eth_tx_tb
  import eth_tx_pkg::*;
();

  typedef logic [7:0] bytes_t [$];

  localparam logic [31:0] SEED = 32'h9776_8d27;
  localparam int SETTLE_CYC  = 40;  // Quiet wire after the last expected frame
  localparam int MAX_FRAMES  = 30;
  localparam int FRAME_CYC   = 600; // 300-byte write, wire time and settle
  localparam int TIMEOUT_CYC = MAX_FRAMES * FRAME_CYC + 2000;

  logic      clk;
  logic      rst;
  logic      arp_req_val;
  arp_req_t  arp_req;
  logic      ipv4_val;
  byte       ipv4_dat;
  mac_addr_t ipv4_dst_mac;
  logic      gmii_val;
  byte       gmii_dat;

  logic [7:0] exp_dat [N_SRC][$]; // Expected wire bytes, per source
  int         exp_len [N_SRC][$]; // Expected frame sizes, per source
  logic [7:0] rx_q [$];           // Frame being collected
  int         src_order [$];      // Source of each received frame
  int         rx_cnt;
  int         rx_len;
  int         gap_cnt = 1000;     // Idle samples before now
  int         cyc;
  bit         quiet;              // Wire must stay idle
  int         mon_errs;
  int         chk_errs;
  int         quiet_errs;
  int         gap_errs;
  int         pre_errs;
  int         tests_run;
  int         tests_failed;
  int         err_base;

  eth_tx_top dut_i (
    .clk          (clk),
    .rst          (rst),
    .arp_req_val  (arp_req_val),
    .arp_req      (arp_req),
    .ipv4_val     (ipv4_val),
    .ipv4_dat     (ipv4_dat),
    .ipv4_dst_mac (ipv4_dst_mac),
    .gmii_val     (gmii_val),
    .gmii_dat     (gmii_dat)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk; // 20 ns period
  end

  // Reflected CRC-32, one data bit per step
  function automatic logic [31:0] crc32_step(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    logic        fb;
    r = c;
    for (int i = 0; i < 8; i++) begin
      fb = r[0] ^ d[i];
      r  = {1'b0, r[31:1]};
      if (fb) r = r ^ 32'hedb8_8320;
    end
    return r;
  endfunction

  function automatic int total_errs();
    return mon_errs + chk_errs + quiet_errs + gap_errs + pre_errs;
  endfunction

  function automatic mac_addr_t rand_mac();
    return {16'($urandom), $urandom};
  endfunction

  function automatic arp_req_t rand_req();
    arp_req_t r;
    r.mac  = rand_mac();
    r.ipv4 = $urandom;
    return r;
  endfunction

  // Whole wire image of one frame, preamble to FCS
  task automatic push_expected(input int src, input mac_addr_t dst, input logic [15:0] et,
                               input bytes_t pld);
    bytes_t      f;
    logic [31:0] crc;
    for (int i = 0; i < 7; i++) f.push_back(8'h55);
    f.push_back(8'hd5);                                         // SFD
    for (int i = 5; i >= 0; i--) f.push_back(dst[i*8 +: 8]);
    for (int i = 5; i >= 0; i--) f.push_back(DEV_MAC[i*8 +: 8]);
    f.push_back(et[15:8]);
    f.push_back(et[7:0]);
    foreach (pld[i]) f.push_back(pld[i]);
    for (int i = pld.size(); i < MIN_PAYLOAD; i++) f.push_back(8'h00); // Zero pad
    crc = 32'hffff_ffff;
    for (int i = 8; i < f.size(); i++) crc = crc32_step(crc, f[i]); // Skips preamble
    crc = ~crc;
    for (int i = 0; i < 4; i++) f.push_back(crc[i*8 +: 8]);          // LSB first
    foreach (f[i]) exp_dat[src].push_back(f[i]);
    exp_len[src].push_back(f.size());
  endtask

  task automatic expect_arp(input arp_req_t r);
    logic [ARP_LEN*8-1:0] v;
    bytes_t               p;
    // Htype 1, ptype IPv4, sizes 6 and 4, opcode 2 for reply
    v = {16'h0001, 16'h0800, 8'h06, 8'h04, 16'h0002, DEV_MAC, DEV_IPV4, r.mac, r.ipv4};
    for (int i = ARP_LEN - 1; i >= 0; i--) p.push_back(v[i*8 +: 8]);
    push_expected(0, r.mac, ETH_TYPE_ARP, p);
  endtask

  task automatic send_arp(input arp_req_t r);
    @(negedge clk);
    arp_req_val = 1'b1; // One-cycle strobe
    arp_req     = r;
    @(negedge clk);
    arp_req_val = 1'b0;
  endtask

  // Random payload of n bytes, expected on the wire or not
  task automatic ipv4_frame(input int n, input bit expected);
    bytes_t    pld;
    mac_addr_t dst;
    dst = rand_mac();
    for (int i = 0; i < n; i++) pld.push_back(8'($urandom));
    if (expected) push_expected(1, dst, ETH_TYPE_IPV4, pld);
    foreach (pld[i]) begin
      @(negedge clk);
      ipv4_val     = 1'b1;
      ipv4_dst_mac = dst;
      ipv4_dat     = pld[i];
    end
    @(negedge clk);
    ipv4_val = 1'b0; // One idle cycle commits the frame
  endtask

  task automatic drain();
    do begin
      @(negedge clk);
    end while (exp_len[0].size() != 0 || exp_len[1].size() != 0 || gap_cnt < SETTLE_CYC);
  endtask

  task automatic end_test(input string name);
    int e;
    e = total_errs() - err_base;
    tests_run++;
    if (e != 0) tests_failed++;
    $display("Test %0d %s: %s, %0d errors", tests_run, name, (e == 0) ? "ok" : "FAILED", e);
    err_base = total_errs();
  endtask

  task automatic check_frame();
    int         src;
    int         n;
    bit         bad;
    logic [7:0] e;
    src = (rx_q.size() > 21 && {rx_q[20], rx_q[21]} == ETH_TYPE_ARP) ? 0 : 1;
    rx_cnt++;
    rx_len = rx_q.size();
    src_order.push_back(src);
    if (exp_len[src].size() == 0) begin
      mon_errs++;
      $display("Unexpected frame of %0d bytes on the wire from source %0d", rx_len, src);
      return;
    end
    n   = exp_len[src].pop_front();
    bad = 1'b0;
    assert (rx_len == n) else begin
      mon_errs++;
      $display("[ERROR] rx_len=%h expected %h", rx_len, n);
    end
    for (int i = 0; i < n; i++) begin
      e = exp_dat[src].pop_front(); // Always pop to stay aligned
      if (!bad && i < rx_len) begin
        assert (rx_q[i] == e) else begin
          mon_errs++;
          bad = 1'b1; // First mismatch only
          $display("[ERROR] gmii_dat=%h expected %h at byte %0d of frame %0d",
                   rx_q[i], e, i, rx_cnt);
        end
      end
    end
  endtask

  // Wire monitor, frame ends when gmii_val drops
  always @(posedge clk) begin
    if (gmii_val) begin
      rx_q.push_back(gmii_dat);
      gap_cnt <= 0;
    end else begin
      if (gap_cnt < 1000) gap_cnt <= gap_cnt + 1;
      if (rx_q.size() != 0) begin
        check_frame();
        rx_q.delete();
      end
    end
  end

  assert property (@(posedge clk) disable iff (rst) quiet |-> !gmii_val)
    else begin
      quiet_errs++;
      $display("[ERROR] gmii_val=%h while no source had sent", gmii_val);
    end

  assert property (@(posedge clk) disable iff (rst) $rose(gmii_val) |-> gap_cnt >= IFG_CYCLES)
    else begin
      gap_errs++;
      $display("[ERROR] gap_cnt=%h before frame start, below %h", gap_cnt, IFG_CYCLES);
    end

  assert property (@(posedge clk) disable iff (rst) $rose(gmii_val) |-> gmii_dat == 8'h55)
    else begin
      pre_errs++;
      $display("[ERROR] gmii_dat=%h at frame start, expected 55", gmii_dat);
    end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc == TIMEOUT_CYC) begin
      $display("Timeout after %0d cycles, the run did not finish", cyc);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    arp_req_t r;
    int       n;
    int       pend_bytes;
    int       pend_frms;
    void'($urandom(SEED));
    rst          = 1'b1;
    arp_req_val  = 1'b0;
    arp_req      = '0;
    ipv4_val     = 1'b0;
    ipv4_dat     = 8'h00;
    ipv4_dst_mac = '0;
    quiet        = 1'b0;
    repeat (8) @(posedge clk); // Reset for 8 cycles
    @(negedge clk);
    rst = 1'b0;

    quiet = 1'b1;
    repeat (50) @(negedge clk);
    quiet = 1'b0;
    assert (rx_cnt == 0) else begin
      chk_errs++;
      $display("A frame appeared before any source sent one");
    end
    end_test("idle after reset");

    r = rand_req();
    expect_arp(r);
    send_arp(r);
    drain();
    assert (rx_len == 72) else begin // 8 + 14 + 46 + 4
      chk_errs++;
      $display("[ERROR] rx_len=%h expected %h", rx_len, 72);
    end
    end_test("single ARP reply");

    pend_bytes = 0;
    pend_frms  = 0;
    for (int i = 0; i < 12; i++) begin
      n = $urandom_range(200, 1);
      if (pend_bytes + n > FIFO_DEPTH || pend_frms == HDR_DEPTH) begin
        drain(); // Keep within buffer space, nothing dropped here
        pend_bytes = 0;
        pend_frms  = 0;
      end
      ipv4_frame(n, 1'b1);
      pend_bytes += n;
      pend_frms++;
    end
    drain();
    end_test("random IPv4 payloads");

    src_order.delete();
    ipv4_frame(150, 1'b1);
    while (!gmii_val) @(negedge clk); // Long frame now on the wire
    ipv4_frame(20, 1'b1);
    ipv4_frame(20, 1'b1);
    r = rand_req();
    expect_arp(r);
    send_arp(r);
    drain();
    assert (src_order.size() == 4 && src_order[0] == 1 && src_order[1] == 0 &&
            src_order[2] == 1 && src_order[3] == 1) else begin
      chk_errs++;
      $display("ARP reply was not sent ahead of the waiting IPv4 frames");
    end
    end_test("ARP priority and gap");

    ipv4_frame(30, 1'b1);
    ipv4_frame(300, 1'b0);  // Larger than the FIFO
    ipv4_frame(30, 1'b1);
    drain();
    ipv4_frame(100, 1'b1);  // Keeps the framer busy
    repeat (4) ipv4_frame(10, 1'b1);
    ipv4_frame(10, 1'b0);   // Header queue full
    drain();
    end_test("overflow drops");

    src_order.delete();
    r = rand_req();
    expect_arp(r);
    send_arp(r);
    repeat (10) @(negedge clk);
    send_arp(rand_req());   // Lands mid-reply
    drain();
    assert (src_order.size() == 1) else begin
      chk_errs++;
      $display("A second ARP strobe during a reply produced %0d frames", src_order.size());
    end
    end_test("ARP strobe while busy");

    $display("Summary: %0d tests, %0d failed, %0d errors, %0d frames received",
             tests_run, tests_failed, total_errs(), rx_cnt);
    if (total_errs() == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: src/eth_tx_top.sv
`timescale 1ns/1ps

module eth_tx_top
  import eth_tx_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      arp_req_val,  // Request seen by receive side
  input  arp_req_t  arp_req,
  input  logic      ipv4_val,     // User stream framing
  input  byte       ipv4_dat,
  input  mac_addr_t ipv4_dst_mac,
  output logic      gmii_val,
  output byte       gmii_dat
);

  logic        src_val [N_SRC]; // Index 0 ARP, 1 IPv4
  byte         src_dat [N_SRC];
  mac_hdr_t    src_hdr [N_SRC];
  logic        frm_avl;
  logic        frm_rd;
  mac_hdr_t    frm_hdr;
  logic [15:0] frm_len;
  logic        pld_rd;
  byte         pld_dat;

  arp_tx_gen arp_tx_gen_i (
    .clk         (clk),
    .rst         (rst),
    .arp_req_val (arp_req_val),
    .arp_req     (arp_req),
    .val         (src_val[0]),
    .dat         (src_dat[0]),
    .hdr         (src_hdr[0])
  );

  // User stream goes straight in as source 1
  assign src_val[1] = ipv4_val;
  assign src_dat[1] = ipv4_dat;
  assign src_hdr[1] = '{dst: ipv4_dst_mac, ethertype: ETH_TYPE_IPV4};

  buf_mng buf_mng_i (
    .clk     (clk),
    .rst     (rst),
    .src_val (src_val),
    .src_dat (src_dat),
    .src_hdr (src_hdr),
    .frm_avl (frm_avl),
    .frm_rd  (frm_rd),
    .frm_hdr (frm_hdr),
    .frm_len (frm_len),
    .pld_rd  (pld_rd),
    .pld_dat (pld_dat)
  );

  mac_tx_framer mac_tx_framer_i (
    .clk      (clk),
    .rst      (rst),
    .frm_avl  (frm_avl),
    .frm_rd   (frm_rd),
    .frm_hdr  (frm_hdr),
    .frm_len  (frm_len),
    .pld_rd   (pld_rd),
    .pld_dat  (pld_dat),
    .gmii_val (gmii_val),
    .gmii_dat (gmii_dat)
  );

endmodule

// File: src/mac_tx_framer.sv
`timescale 1ns/1ps

module mac_tx_framer
  import eth_tx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        frm_avl,
  output logic        frm_rd,
  input  mac_hdr_t    frm_hdr,
  input  logic [15:0] frm_len,
  output logic        pld_rd,
  input  byte         pld_dat,
  output logic        gmii_val,
  output byte         gmii_dat
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_PRE,
    ST_HDR,
    ST_PLD,
    ST_PAD,
    ST_FCS,
    ST_IFG
  } state_t;

  state_t                   state;
  logic [15:0]              cnt;  // Byte index within state
  logic [31:0]              crc;  // Running CRC, not inverted
  logic [31:0]              fcs;
  logic [ETH_HDR_LEN*8-1:0] hdr_bytes;

  // One byte of reflected CRC-32
  function automatic logic [31:0] crc_byte(input logic [31:0] c, input logic [7:0] d);
    logic [31:0] r;
    r = c ^ {24'd0, d};
    for (int i = 0; i < 8; i++) begin
      r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
    end
    return r;
  endfunction

  assign hdr_bytes = {frm_hdr.dst, DEV_MAC, frm_hdr.ethertype};
  assign fcs       = ~crc;

  assign frm_rd   = (state == ST_IDLE) && frm_avl;
  assign pld_rd   = ((state == ST_HDR) && (cnt == 16'(ETH_HDR_LEN - 1))) || // First byte early
                    ((state == ST_PLD) && (cnt < frm_len - 16'd1));
  assign gmii_val = state inside {ST_PRE, ST_HDR, ST_PLD, ST_PAD, ST_FCS};

  always_comb begin
    gmii_dat = 8'h00; // Pad and idle
    case (state)
      ST_PRE:  gmii_dat = (cnt == 16'(PRE_LEN - 1)) ? SFD_BYTE : PRE_BYTE;
      ST_HDR:  gmii_dat = hdr_bytes[(ETH_HDR_LEN - 1 - cnt[3:0]) * 8 +: 8];
      ST_PLD:  gmii_dat = pld_dat;
      ST_FCS:  gmii_dat = fcs[cnt[1:0] * 8 +: 8]; // LSB first
      default: gmii_dat = 8'h00;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
      cnt   <= '0;
      crc   <= '1;
    end else begin
      cnt <= cnt + 16'd1;
      if (state inside {ST_HDR, ST_PLD, ST_PAD}) crc <= crc_byte(crc, gmii_dat);
      case (state)
        ST_IDLE: begin
          crc <= '1; // CRC seed
          cnt <= '0;
          if (frm_avl) state <= ST_PRE; // frm_rd fires here
        end
        ST_PRE: begin
          if (cnt == 16'(PRE_LEN - 1)) begin
            state <= ST_HDR;
            cnt   <= '0;
          end
        end
        ST_HDR: begin
          if (cnt == 16'(ETH_HDR_LEN - 1)) begin
            state <= ST_PLD;
            cnt   <= '0;
          end
        end
        ST_PLD: begin
          if (cnt == frm_len - 16'd1) begin
            if (frm_len < 16'(MIN_PAYLOAD)) begin
              state <= ST_PAD; // cnt keeps counting payload position
            end else begin
              state <= ST_FCS;
              cnt   <= '0;
            end
          end
        end
        ST_PAD: begin
          if (cnt == 16'(MIN_PAYLOAD - 1)) begin
            state <= ST_FCS;
            cnt   <= '0;
          end
        end
        ST_FCS: begin
          if (cnt == 16'(FCS_LEN - 1)) begin
            state <= ST_IFG;
            cnt   <= '0;
          end
        end
        default: begin // IFG
          if (cnt == 16'(IFG_CYCLES - 1)) state <= ST_IDLE;
        end
      endcase
    end
  end

  // Frame length from buf_mng held for the whole frame
  assert property (@(posedge clk) disable iff (rst)
    state inside {ST_HDR, ST_PLD, ST_PAD, ST_FCS} |-> $stable(frm_len))
    else $error("[ERROR] frm_len=%h changed mid-frame", frm_len);

endmodule

// File: src/buf_mng.sv
`timescale 1ns/1ps

module buf_mng
  import eth_tx_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        src_val [N_SRC],
  input  byte         src_dat [N_SRC],
  input  mac_hdr_t    src_hdr [N_SRC],
  output logic        frm_avl, // Any committed frame waiting
  input  logic        frm_rd,  // Select next frame
  output mac_hdr_t    frm_hdr,
  output logic [15:0] frm_len,
  input  logic        pld_rd,  // One byte request
  output byte         pld_dat
);

  localparam int AW = $clog2(FIFO_DEPTH);
  localparam int HW = $clog2(HDR_DEPTH);
  localparam int SW = $clog2(N_SRC);

  typedef struct packed {
    logic [15:0] len;
    mac_hdr_t    hdr;
  } hq_ent_t;

  byte         mem     [N_SRC][FIFO_DEPTH]; // Byte FIFOs
  hq_ent_t     hq      [N_SRC][HDR_DEPTH];  // Length and header queues
  logic [AW:0] wr_ptr  [N_SRC];             // Tentative write
  logic [AW:0] wr_base [N_SRC];             // Start of open frame
  logic [AW:0] rd_ptr  [N_SRC];
  logic [HW:0] hq_wr   [N_SRC];
  logic [HW:0] hq_rd   [N_SRC];
  logic        val_q   [N_SRC];             // For falling edge
  logic        ovf     [N_SRC];             // Open frame doomed
  logic [15:0] len_cnt [N_SRC];
  mac_hdr_t    hdr_lat [N_SRC];

  logic [N_SRC-1:0] hq_nempty;
  logic [N_SRC-1:0] hq_full;
  logic [N_SRC-1:0] wr_en;
  logic [N_SRC-1:0] commit; // val just fell
  logic [N_SRC-1:0] keep;   // Commit that survives
  logic [SW-1:0]    pick;   // Priority winner
  logic [SW-1:0]    sel;    // Source being read
  logic             sel_val;
  logic [15:0]      rd_cnt; // Bytes read of current frame

  always_comb begin
    for (int s = 0; s < N_SRC; s++) begin
      hq_nempty[s] = hq_wr[s] != hq_rd[s];
      hq_full[s]   = (hq_wr[s] - hq_rd[s]) == (HW + 1)'(HDR_DEPTH);
      wr_en[s]     = src_val[s] && !ovf[s] &&
                     ((wr_ptr[s] - rd_ptr[s]) != (AW + 1)'(FIFO_DEPTH));
      commit[s]    = val_q[s] && !src_val[s];
      keep[s]      = commit[s] && !ovf[s] && !hq_full[s];
    end
  end

  // Lowest index wins, ARP first
  always_comb begin
    pick = '0;
    for (int s = N_SRC - 1; s >= 0; s--) begin
      if (hq_nempty[s]) pick = SW'(s);
    end
  end

  assign frm_avl = |hq_nempty;

  // Pointers and frame bookkeeping
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int s = 0; s < N_SRC; s++) begin
        wr_ptr[s]  <= '0;
        wr_base[s] <= '0;
        rd_ptr[s]  <= '0;
        hq_wr[s]   <= '0;
        hq_rd[s]   <= '0;
        val_q[s]   <= 1'b0;
        ovf[s]     <= 1'b0;
        len_cnt[s] <= '0;
      end
      sel     <= '0;
      sel_val <= 1'b0;
      rd_cnt  <= '0;
    end else begin
      for (int s = 0; s < N_SRC; s++) begin
        val_q[s] <= src_val[s];
        if (wr_en[s]) begin
          wr_ptr[s]  <= wr_ptr[s] + 1'b1;
          len_cnt[s] <= len_cnt[s] + 16'd1;
        end else if (src_val[s]) begin
          ovf[s] <= 1'b1; // FIFO full mid-frame
        end
        if (commit[s]) begin
          len_cnt[s] <= '0;
          ovf[s]     <= 1'b0;
          if (keep[s]) begin
            hq_wr[s]   <= hq_wr[s] + 1'b1;
            wr_base[s] <= wr_ptr[s];
          end else begin
            wr_ptr[s] <= wr_base[s]; // Rewind, drop whole frame
          end
        end
        if (frm_rd && frm_avl && pick == SW'(s)) hq_rd[s] <= hq_rd[s] + 1'b1;
        if (pld_rd && sel == SW'(s)) rd_ptr[s] <= rd_ptr[s] + 1'b1;
      end
      if (frm_rd && frm_avl) begin
        sel     <= pick;
        sel_val <= 1'b1;
        rd_cnt  <= '0;
      end else if (pld_rd) begin
        rd_cnt <= rd_cnt + 16'd1;
        if (rd_cnt + 16'd1 == frm_len) sel_val <= 1'b0; // Frame drained
      end
    end
  end

  // Storage and read data
  always_ff @(posedge clk) begin
    for (int s = 0; s < N_SRC; s++) begin
      if (wr_en[s]) mem[s][wr_ptr[s][AW-1:0]] <= src_dat[s];
      if (src_val[s] && !val_q[s]) hdr_lat[s] <= src_hdr[s]; // First byte
      if (keep[s]) hq[s][hq_wr[s][HW-1:0]] <= '{len: len_cnt[s], hdr: hdr_lat[s]};
    end
    if (frm_rd && frm_avl) begin
      frm_hdr <= hq[pick][hq_rd[pick][HW-1:0]].hdr;
      frm_len <= hq[pick][hq_rd[pick][HW-1:0]].len;
    end
    if (pld_rd) pld_dat <= mem[sel][rd_ptr[sel][AW-1:0]]; // One cycle latency
  end

  assert property (@(posedge clk) disable iff (rst) pld_rd |-> sel_val)
    else $error("[ERROR] pld_rd with no frame selected");

  // Framer stops requesting after the last byte
  assert property (@(posedge clk) disable iff (rst)
    (pld_rd && rd_cnt == frm_len - 16'd1) |=> !pld_rd)
    else $error("[ERROR] pld_rd past frm_len=%h", frm_len);

endmodule

// File: src/arp_tx_gen.sv
`timescale 1ns/1ps

module arp_tx_gen
  import eth_tx_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     arp_req_val, // One-cycle request strobe
  input  arp_req_t arp_req,
  output logic     val,
  output byte      dat,
  output mac_hdr_t hdr
);

  arp_req_t                   req_q; // Captured requester
  logic [4:0]                 cnt;   // Reply byte index
  logic [ARP_LEN*8-1:0]       pld;   // Whole reply, first byte on top

  // Reply fields in wire order
  assign pld = {
    ARP_HTYPE,
    ETH_TYPE_IPV4, // Protocol type
    ARP_HLEN,
    ARP_PLEN,
    ARP_OPER,
    DEV_MAC,       // Sender hardware address
    DEV_IPV4,      // Sender protocol address
    req_q.mac,     // Target hardware address
    req_q.ipv4     // Target protocol address
  };

  assign dat = pld[(ARP_LEN - 1 - cnt) * 8 +: 8]; // Byte select by index
  assign hdr = '{dst: req_q.mac, ethertype: ETH_TYPE_ARP};

  // Control FSM, idle or sending
  always_ff @(posedge clk) begin
    if (rst) begin
      val <= 1'b0;
      cnt <= '0;
    end else if (!val) begin
      if (arp_req_val) begin // Strobes while busy fall through
        val <= 1'b1;
        cnt <= '0;
      end
    end else begin
      cnt <= cnt + 5'd1;
      if (cnt == 5'(ARP_LEN - 1)) begin
        val <= 1'b0; // Last byte out
      end
    end
  end

  // Request capture, no reset on payload
  always_ff @(posedge clk) begin
    if (arp_req_val && !val) begin
      req_q <= arp_req;
    end
  end

  // Reply length bounded, so buf_mng sees one frame per reply
  assert property (@(posedge clk) disable iff (rst) $rose(val) |-> ##[1:ARP_LEN] !val)
    else $error("[ERROR] arp_tx_gen val high longer than %0d cycles", ARP_LEN);

endmodule

// File: src/eth_tx_pkg.sv
package eth_tx_pkg;

  typedef logic [47:0] mac_addr_t; // Ethernet station address
  typedef logic [31:0] ipv4_t;     // IPv4 address

  // Per-frame header supplied by each source
  typedef struct packed {
    mac_addr_t   dst;       // Destination MAC
    logic [15:0] ethertype; // Payload protocol
  } mac_hdr_t;

  // ARP request as reported by the receive side
  typedef struct packed {
    mac_addr_t mac;  // Requester MAC, reply target
    ipv4_t     ipv4; // Requester IPv4, reply target
  } arp_req_t;

  // Device identity
  localparam mac_addr_t DEV_MAC  = 48'h02_00_5e_10_20_30; // Locally administered
  localparam ipv4_t     DEV_IPV4 = 32'hc0_a8_00_0a;       // 192.168.0.10

  localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
  localparam logic [15:0] ETH_TYPE_ARP  = 16'h0806;

  // Buffer sizing
  localparam int FIFO_DEPTH = 256; // Bytes per source
  localparam int HDR_DEPTH  = 4;   // Frames per source
  localparam int N_SRC      = 2;   // 0 ARP, 1 IPv4

  // Wire format
  localparam int MIN_PAYLOAD = 46; // Pad target
  localparam int IFG_CYCLES  = 12; // Idle bytes after FCS
  localparam int PRE_LEN     = 8;  // Preamble plus SFD
  localparam int ETH_HDR_LEN = 14; // Dst, src, type
  localparam int FCS_LEN     = 4;
  localparam int ARP_LEN     = 28; // ARP reply payload

  localparam logic [7:0]  PRE_BYTE = 8'h55;
  localparam logic [7:0]  SFD_BYTE = 8'hd5;
  localparam logic [31:0] CRC_POLY = 32'hedb8_8320; // Reflected CRC-32

  // ARP reply field constants
  localparam logic [15:0] ARP_HTYPE = 16'h0001; // Ethernet
  localparam logic [7:0]  ARP_HLEN  = 8'd6;
  localparam logic [7:0]  ARP_PLEN  = 8'd4;
  localparam logic [15:0] ARP_OPER  = 16'h0002; // Reply

endpackage
